//--- verilog/cart_pkg.sv
// Shared widths, header offsets, fill patterns and bus types of the cartridge loader.
// Compile first; modules name its types in their ports and import it in their bodies.
package cart_pkg;

	// ====================
	// Widths and offsets
	// ====================
	localparam int DL_ADDR_W    = 25;
	localparam int WRAM_ADDR_W  = 17;
	localparam int SECTOR_SHIFT = 9;

	// Copier header in front of the ROM image
	localparam logic [DL_ADDR_W-1:0] HEADER_SKIP = 25'h200;

	// Size field of the internal header in each memory map
	localparam logic [DL_ADDR_W-1:0] HDR_LOROM   = 25'h007FD6;
	localparam logic [DL_ADDR_W-1:0] HDR_HIROM   = 25'h00FFD6;
	localparam logic [DL_ADDR_W-1:0] HDR_EXHIROM = 25'h40FFD6;

	// Download index of cheat code files
	localparam logic [7:0] CODE_KIND = 8'hFF;

	// ====================
	// Menu encodings
	// ====================
	typedef enum logic [2:0] {
		mode_auto      = 3'd0,
		mode_no_header = 3'd1,
		mode_lorom     = 3'd2,
		mode_hirom     = 3'd3,
		mode_exhirom   = 3'd4
	} header_mode_e;

	// Work RAM contents at power on, as on the various console revisions
	typedef enum logic [1:0] {
		fill_9966 = 2'd0,
		fill_00ff = 2'd1,
		fill_55   = 2'd2,
		fill_ff   = 2'd3
	} fill_pattern_e;

	typedef struct packed {
		header_mode_e  hdr_mode;
		logic [1:0]    region_override;
		fill_pattern_e fill_pattern;
		logic          autosave;
		logic          load_req;
		logic          save_req;
	} menu_t;

	// ====================
	// Bus types
	// ====================
	typedef struct packed {
		logic                 active;
		logic [7:0]           index;
		logic [DL_ADDR_W-1:0] addr;
		logic [15:0]          data;
		logic                 wr;
	} dl_bus_t;

	typedef struct packed {
		logic [7:0]  rom_type;
		logic [23:0] rom_mask;
		logic [23:0] ram_mask;
		logic        region;
	} cart_info_t;

	// Layout matches the cheat engine, integers kept in big endian order
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] addr;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	typedef struct packed {
		logic [WRAM_ADDR_W-1:0] addr;
		logic [7:0]             data;
		logic                   wr;
	} fill_write_t;

	typedef struct packed {
		logic mounted;
		logic readonly;
		logic size_nz;
	} img_t;

	typedef struct packed {
		logic [31:0] lba;
		logic        rd;
		logic        wr;
	} sd_req_t;

endpackage

//--- verilog/loader_config.sv
// Menu settings register and download classifier.
// Settings that shape a download are frozen while a cartridge is loading.
module loader_config (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  cart_pkg::menu_t         menu,
	input  cart_pkg::dl_bus_t       dl,
	output cart_pkg::header_mode_e  hdr_mode,
	output logic [1:0]              region_override,
	output cart_pkg::fill_pattern_e fill_pattern,
	output logic                    autosave,
	output logic                    load_req,
	output logic                    save_req,
	output logic                    cart_dl,
	output logic                    code_dl
);
	import cart_pkg::*;

	// Cheat files use the all ones index, everything else is a cartridge
	assign code_dl = dl.active & (dl.index == CODE_KIND);
	assign cart_dl = dl.active & (dl.index != CODE_KIND);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			hdr_mode        <= mode_auto;
			fill_pattern    <= fill_9966;
			region_override <= 2'd0;
			autosave        <= 1'b0;
			load_req        <= 1'b0;
			save_req        <= 1'b0;
		end else begin
			if (!cart_dl) begin
				hdr_mode     <= menu.hdr_mode;
				fill_pattern <= menu.fill_pattern;
			end
			region_override <= menu.region_override;
			autosave        <= menu.autosave;
			load_req        <= menu.load_req;
			save_req        <= menu.save_req;
		end
	end

endmodule

//--- verilog/header_detect.sv
// ROM header detection during a cartridge download.
// Derives ROM type, ROM and RAM address masks and the header region,
// and chooses the video region once the download is over.
module header_detect (
	input  logic                   clk_sys,
	input  logic                   RESET,
	input  cart_pkg::dl_bus_t      dl,
	input  logic                   cart_dl,
	input  cart_pkg::header_mode_e hdr_mode,
	input  logic [1:0]             region_override,
	output cart_pkg::cart_info_t   cart_info,
	output logic                   pal
);
	import cart_pkg::*;

	logic [3:0]           rom_size;
	logic [3:0]           ram_size;
	logic [3:0]           rom_size_nxt;
	logic [3:0]           ram_size_nxt;
	logic [7:0]           type_nxt;
	logic                 has_layout;
	logic [DL_ADDR_W-1:0] size_addr;

	// Location of the size field for the forced memory maps
	always_comb begin
		has_layout = 1'b1;
		case (hdr_mode)
			mode_lorom:   size_addr = HDR_LOROM + HEADER_SKIP;
			mode_hirom:   size_addr = HDR_HIROM + HEADER_SKIP;
			mode_exhirom: size_addr = HDR_EXHIROM + HEADER_SKIP;
			default: begin
				has_layout = 1'b0;
				size_addr  = '0;
			end
		endcase
	end

	always_comb begin
		rom_size_nxt = rom_size;
		ram_size_nxt = ram_size;
		type_nxt     = cart_info.rom_type;
		if (dl.addr == '0) begin
			// Defaults unless the loader put sizes in the first word
			rom_size_nxt = 4'hC;
			ram_size_nxt = 4'h0;
			if (hdr_mode == mode_auto && dl.data[7:0] != 8'd0)
				{ram_size_nxt, rom_size_nxt} = dl.data[7:0];
			case (hdr_mode)
				mode_no_header: type_nxt = 8'd0;
				mode_lorom:     type_nxt = 8'd0;
				mode_hirom:     type_nxt = 8'd1;
				mode_exhirom:   type_nxt = 8'd2;
				default:        type_nxt = dl.data[15:8];
			endcase
		end
		if (has_layout && dl.addr == size_addr)
			rom_size_nxt = dl.data[11:8];
		if (has_layout && dl.addr == size_addr + DL_ADDR_W'(2))
			ram_size_nxt = dl.data[3:0];
	end

	always_ff @(posedge clk_sys) begin
		if (cart_dl && dl.wr) begin
			rom_size <= rom_size_nxt;
			ram_size <= ram_size_nxt;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_info <= '0;
			pal       <= 1'b0;
		end else begin
			if (cart_dl && dl.wr) begin
				cart_info.rom_type <= type_nxt;
				cart_info.rom_mask <= (24'd1024 << rom_size_nxt) - 24'd1;
				cart_info.ram_mask <= (ram_size_nxt != 4'd0) ?
					(24'd1024 << ram_size_nxt) - 24'd1 : 24'd0;
				if (dl.addr == DL_ADDR_W'(2))
					cart_info.region <= dl.data[8];
			end
			// Nonzero override wins over the header
			if (!cart_dl)
				pal <= (region_override == 2'd0) ? cart_info.region : region_override[1];
		end
	end

endmodule

//--- verilog/cheat_assembler.sv
// Builds 128-bit cheat records from a cheat code download.
// Eight words make a record, the last word strobes it to the cheat engine.
module cheat_assembler (
	input  logic                  clk_sys,
	input  logic                  RESET,
	input  cart_pkg::dl_bus_t     dl,
	input  logic                  cart_dl,
	input  logic                  code_dl,
	output cart_pkg::cheat_code_t cheat,
	output logic                  cheat_valid,
	output logic                  cheat_reset
);

	// A new code file or a new cartridge flushes the stored cheats
	assign cheat_reset = (code_dl & dl.wr & (dl.addr == '0)) | cart_dl;

	always_ff @(posedge clk_sys) begin
		if (code_dl && dl.wr) begin
			case (dl.addr[3:0])
				4'd0:  cheat.flags[15:0]    <= dl.data;
				4'd2:  cheat.flags[31:16]   <= dl.data;
				4'd4:  cheat.addr[15:0]     <= dl.data;
				4'd6:  cheat.addr[31:16]    <= dl.data;
				4'd8:  cheat.compare[15:0]  <= dl.data;
				4'd10: cheat.compare[31:16] <= dl.data;
				4'd12: cheat.replace[15:0]  <= dl.data;
				4'd14: cheat.replace[31:16] <= dl.data;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET)
			cheat_valid <= 1'b0;
		else
			cheat_valid <= code_dl & dl.wr & (dl.addr[3:0] == 4'd14);
	end

endmodule

//--- verilog/wram_clear.sv
// Work RAM clear at the start of each cartridge download.
// Writes the selected power-on pattern once over the whole work RAM.
module wram_clear (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  logic                    cart_dl,
	input  cart_pkg::fill_pattern_e fill_pattern,
	output cart_pkg::fill_write_t   fill,
	output logic                    clear_busy
);
	import cart_pkg::*;

	logic                   cart_dl_d;
	logic [WRAM_ADDR_W-1:0] fill_addr;
	logic [7:0]             fill_data;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_dl_d  <= 1'b0;
			clear_busy <= 1'b0;
			fill_addr  <= '0;
		end else begin
			cart_dl_d <= cart_dl;
			if (clear_busy) begin
				fill_addr <= fill_addr + 1'b1;
				if (&fill_addr)
					clear_busy <= 1'b0;
			end
			if (cart_dl && !cart_dl_d) begin
				clear_busy <= 1'b1;
				fill_addr  <= '0;
			end
		end
	end

	always_comb begin
		case (fill_pattern)
			fill_9966: fill_data = (fill_addr[8] ^ fill_addr[2]) ? 8'h66 : 8'h99;
			fill_00ff: fill_data = (fill_addr[9] ^ fill_addr[0]) ? 8'hFF : 8'h00;
			fill_55:   fill_data = 8'h55;
			default:   fill_data = 8'hFF;
		endcase
	end

	assign fill = '{addr: fill_addr, data: fill_data, wr: clear_busy};

endmodule

//--- verilog/backup_sequencer.sv
// Backup RAM transfers with the mounted save image.
// Loads after a download or on request, saves on request or by autosave,
// moving one 512-byte sector per request and acknowledge handshake.
module backup_sequencer (
	input  logic                 clk_sys,
	input  logic                 RESET,
	input  logic                 cart_dl,
	input  cart_pkg::cart_info_t cart_info,
	input  cart_pkg::img_t       img,
	input  logic                 load_req,
	input  logic                 save_req,
	input  logic                 autosave,
	input  logic                 osd_status,
	input  logic                 bsram_write,
	input  logic                 sd_ack,
	output cart_pkg::sd_req_t    sd_req,
	output logic                 bk_busy,
	output logic                 led_user
);
	import cart_pkg::*;

	logic        cart_dl_d;
	logic        bk_ena;
	logic        pending;
	logic        old_load;
	logic        old_save;
	logic        old_ack;
	logic        loading;
	logic        save_level;
	logic        load_rise;
	logic        save_rise;
	logic        auto_load;
	logic        start;
	logic        start_load;
	logic [31:0] last_lba;

	// ====================
	// Trigger conditions
	// ====================
	assign save_level = save_req | (pending & osd_status & autosave);
	assign load_rise  = load_req & bk_ena & ~old_load;
	assign save_rise  = save_level & bk_ena & ~old_save;
	assign auto_load  = cart_dl_d & ~cart_dl & img.size_nz & bk_ena;
	assign start_load = load_rise | auto_load;
	assign start      = ~bk_busy & (start_load | save_rise);
	assign last_lba   = 32'(cart_info.ram_mask >> SECTOR_SHIFT);

	assign led_user = cart_dl | (autosave & pending);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_dl_d <= 1'b0;
			bk_ena    <= 1'b0;
			pending   <= 1'b0;
		end else begin
			cart_dl_d <= cart_dl;
			if (cart_dl && !cart_dl_d)
				bk_ena <= 1'b0;
			// Save image is mounted by the time the download finishes
			if (cart_dl && img.mounted && !img.readonly)
				bk_ena <= |cart_info.ram_mask;
			if (start)
				pending <= 1'b0;
			else if (bk_ena && !osd_status && bsram_write)
				pending <= 1'b1;
		end
	end

	// ====================
	// Sector handshake
	// ====================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_load <= 1'b0;
			old_save <= 1'b0;
			old_ack  <= 1'b0;
			bk_busy  <= 1'b0;
			loading  <= 1'b0;
			sd_req   <= '0;
		end else begin
			old_load <= load_req & bk_ena;
			old_save <= save_level & bk_ena;
			old_ack  <= sd_ack;
			if (sd_ack && !old_ack) begin
				sd_req.rd <= 1'b0;
				sd_req.wr <= 1'b0;
			end
			if (start) begin
				bk_busy    <= 1'b1;
				loading    <= start_load;
				sd_req.lba <= 32'd0;
				sd_req.rd  <= start_load;
				sd_req.wr  <= ~start_load;
			end else if (bk_busy && old_ack && !sd_ack) begin
				// Sector done, move on or finish
				if (sd_req.lba >= last_lba) begin
					bk_busy <= 1'b0;
					loading <= 1'b0;
				end else begin
					sd_req.lba <= sd_req.lba + 32'd1;
					sd_req.rd  <= loading;
					sd_req.wr  <= ~loading;
				end
			end
		end
	end

endmodule

//--- verilog/cart_loader.sv
// Cartridge loading side of the emulator core.
// Takes the download stream and menu settings, and produces the cartridge
// description, cheat records, work RAM clear writes and save image requests.
module cart_loader (
	input  logic                 clk_sys,
	input  logic                 RESET,
	input  cart_pkg::menu_t      menu,
	input  cart_pkg::dl_bus_t    dl,
	input  cart_pkg::img_t       img,
	input  logic                 sd_ack,
	input  logic                 osd_status,
	input  logic                 bsram_write,
	output cart_pkg::cart_info_t cart_info,
	output logic                 pal,
	output cart_pkg::cheat_code_t cheat,
	output logic                 cheat_valid,
	output logic                 cheat_reset,
	output cart_pkg::fill_write_t fill,
	output logic                 clear_busy,
	output cart_pkg::sd_req_t    sd_req,
	output logic                 bk_busy,
	output logic                 led_user
);
	import cart_pkg::*;

	header_mode_e  hdr_mode;
	logic [1:0]    region_override;
	fill_pattern_e fill_pattern;
	logic          autosave;
	logic          load_req;
	logic          save_req;
	logic          cart_dl;
	logic          code_dl;

	loader_config u_config (
		.clk_sys        (clk_sys),
		.RESET          (RESET),
		.menu           (menu),
		.dl             (dl),
		.hdr_mode       (hdr_mode),
		.region_override(region_override),
		.fill_pattern   (fill_pattern),
		.autosave       (autosave),
		.load_req       (load_req),
		.save_req       (save_req),
		.cart_dl        (cart_dl),
		.code_dl        (code_dl)
	);

	header_detect u_header (
		.clk_sys        (clk_sys),
		.RESET          (RESET),
		.dl             (dl),
		.cart_dl        (cart_dl),
		.hdr_mode       (hdr_mode),
		.region_override(region_override),
		.cart_info      (cart_info),
		.pal            (pal)
	);

	cheat_assembler u_cheat (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.dl         (dl),
		.cart_dl    (cart_dl),
		.code_dl    (code_dl),
		.cheat      (cheat),
		.cheat_valid(cheat_valid),
		.cheat_reset(cheat_reset)
	);

	wram_clear u_clear (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.cart_dl     (cart_dl),
		.fill_pattern(fill_pattern),
		.fill        (fill),
		.clear_busy  (clear_busy)
	);

	backup_sequencer u_backup (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.cart_dl    (cart_dl),
		.cart_info  (cart_info),
		.img        (img),
		.load_req   (load_req),
		.save_req   (save_req),
		.autosave   (autosave),
		.osd_status (osd_status),
		.bsram_write(bsram_write),
		.sd_ack     (sd_ack),
		.sd_req     (sd_req),
		.bk_busy    (bk_busy),
		.led_user   (led_user)
	);

endmodule

//--- bench/tb_clock.sv
// Clock and reset source for the cart loader testbench.
// clk_sys runs at 40 ns, RESET is held for the first two rising edges.
module tb_clock (
	output logic clk_sys,
	output logic RESET
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// Release on a falling edge so the DUT sees a clean first cycle
	initial begin
		RESET = 1'b1;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		RESET = 1'b0;
	end

endmodule

//--- bench/tb_cart_loader.sv
// Directed testbench for the cartridge loader.
// Covers header detection, cheat records, work RAM clear and backup RAM transfers,
// then prints one summary line and the final verdict.
module tb_cart_loader;
	timeunit 1ns;
	timeprecision 1ps;
	import cart_pkg::*;

	localparam int WRAM_WORDS = 1 << WRAM_ADDR_W;

	logic        clk_sys;
	logic        RESET;
	menu_t       menu;
	dl_bus_t     dl;
	img_t        img;
	logic        sd_ack;
	logic        osd_status;
	logic        bsram_write;
	cart_info_t  cart_info;
	logic        pal;
	cheat_code_t cheat;
	logic        cheat_valid;
	logic        cheat_reset;
	fill_write_t fill;
	logic        clear_busy;
	sd_req_t     sd_req;
	logic        bk_busy;
	logic        led_user;

	integer  seed = 12652;
	int      mismatch_count = 0;
	int      failure_count = 0;
	int      valid_count = 0;
	int      reset_count = 0;
	sd_req_t req_log[$];

	tb_clock u_clock (
		.clk_sys(clk_sys),
		.RESET  (RESET)
	);

	cart_loader uut (.*);

	// ====================
	// Monitors and models
	// ====================
	// Cheat strobes counted on the rising edge
	always @(posedge clk_sys) begin
		if (cheat_valid)
			valid_count <= valid_count + 1;
		if (cheat_reset)
			reset_count <= reset_count + 1;
	end

	// Save image model answering each sector request after 1 to 8 cycles
	// and holding ack for 4 cycles
	initial begin
		sd_ack = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (sd_req.rd || sd_req.wr) begin
				req_log.push_back(sd_req);
				repeat (1 + ($unsigned($random(seed)) % 8)) @(negedge clk_sys);
				sd_ack = 1'b1;
				repeat (4) @(negedge clk_sys);
				sd_ack = 1'b0;
			end
		end
	end

	// ====================
	// Compare helpers
	// ====================
	task automatic check_info(input string name, input cart_info_t got,
			input cart_info_t expected);
		if (got !== expected) begin
			$display("MISMATCH %s: got %h expected %h", name, got, expected);
			mismatch_count++;
		end
	endtask

	task automatic check_cheat(input string name, input cheat_code_t got,
			input cheat_code_t expected);
		if (got !== expected) begin
			$display("MISMATCH %s: got %h expected %h", name, got, expected);
			mismatch_count++;
		end
	endtask

	task automatic check_fill(input string name, input fill_write_t got,
			input fill_write_t expected);
		if (got !== expected) begin
			$display("MISMATCH %s: got %h expected %h", name, got, expected);
			mismatch_count++;
		end
	endtask

	task automatic check_req(input string name, input sd_req_t got, input sd_req_t expected);
		if (got !== expected) begin
			$display("MISMATCH %s: got %h expected %h", name, got, expected);
			mismatch_count++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic expected);
		if (got !== expected) begin
			$display("MISMATCH %s: got %h expected %h", name, got, expected);
			mismatch_count++;
		end
	endtask

	task automatic note_failure(input string msg);
		$display("%s", msg);
		failure_count++;
	endtask

	function automatic logic [7:0] pattern_byte(input fill_pattern_e pattern,
			input logic [WRAM_ADDR_W-1:0] addr);
		case (pattern)
			fill_9966: return (addr[8] ^ addr[2]) ? 8'h66 : 8'h99;
			fill_00ff: return (addr[9] ^ addr[0]) ? 8'hFF : 8'h00;
			fill_55:   return 8'h55;
			default:   return 8'hFF;
		endcase
	endfunction

	// ====================
	// Stimulus helpers
	// ====================
	task automatic idle(input int cycles);
		repeat (cycles) @(negedge clk_sys);
	endtask

	task automatic wait_clear_state(input logic level, input int limit);
		int n;
		n = 0;
		while (clear_busy !== level && n < limit) begin
			@(negedge clk_sys);
			n++;
		end
		if (clear_busy !== level)
			note_failure($sformatf("Timeout: clear_busy did not reach %0b in %0d cycles",
				level, limit));
	endtask

	task automatic wait_backup_state(input logic level, input int limit);
		int n;
		n = 0;
		while (bk_busy !== level && n < limit) begin
			@(negedge clk_sys);
			n++;
		end
		if (bk_busy !== level)
			note_failure($sformatf("Timeout: bk_busy did not reach %0b in %0d cycles",
				level, limit));
	endtask

	task automatic start_download(input logic [7:0] index);
		dl.active = 1'b1;
		dl.index  = index;
		dl.wr     = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic write_word(input logic [DL_ADDR_W-1:0] addr, input logic [15:0] data);
		dl.addr = addr;
		dl.data = data;
		dl.wr   = 1'b1;
		@(negedge clk_sys);
		dl.wr = 1'b0;
	endtask

	task automatic end_download();
		dl.active = 1'b0;
		dl.wr     = 1'b0;
		@(negedge clk_sys);
	endtask

	// ====================
	// Directed tests
	// ====================
	task automatic auto_header();
		cart_info_t expected;
		int i;
		menu.hdr_mode        = mode_auto;
		menu.region_override = 2'd2;
		idle(2);
		start_download(8'h00);
		// Type 0x21, RAM size 3, ROM size 0xB
		write_word('0, 16'h213B);
		write_word(DL_ADDR_W'(2), 16'h0000);
		for (i = 4; i < 16; i += 2)
			write_word(DL_ADDR_W'(i), 16'($random(seed)));
		end_download();
		idle(2);
		// 2 MB of ROM and 8 KB of RAM
		expected = '{rom_type: 8'h21, rom_mask: 24'h1FFFFF, ram_mask: 24'h001FFF,
			region: 1'b0};
		check_info("cart_info auto", cart_info, expected);
		check_bit("pal override 2", pal, 1'b1);
		menu.region_override = 2'd0;
		idle(3);
		check_bit("pal from header", pal, 1'b0);
	endtask

	task automatic forced_hirom();
		cart_info_t  expected;
		logic [15:0] region_word;
		menu.hdr_mode = mode_hirom;
		idle(2);
		region_word = 16'($random(seed));
		// PAL header so pal has to follow the header region
		region_word[8] = 1'b1;
		start_download(8'h01);
		write_word('0, 16'($random(seed)));
		write_word(DL_ADDR_W'(2), region_word);
		// Mode is frozen during the download
		menu.hdr_mode = mode_auto;
		write_word(HDR_HIROM + HEADER_SKIP, 16'h0A00);
		write_word(HDR_HIROM + HEADER_SKIP + DL_ADDR_W'(2), 16'h0003);
		end_download();
		idle(2);
		// 1 MB of ROM and 8 KB of RAM
		expected = '{rom_type: 8'h01, rom_mask: 24'h0FFFFF, ram_mask: 24'h001FFF,
			region: 1'b1};
		check_info("cart_info hirom", cart_info, expected);
		check_bit("pal from hirom header", pal, 1'b1);
	endtask

	task automatic cheat_record();
		logic [15:0] words[8];
		cheat_code_t expected;
		int          valid_start;
		int          reset_start;
		int          i;
		for (i = 0; i < 8; i++)
			words[i] = 16'($random(seed));
		valid_start = valid_count;
		reset_start = reset_count;
		start_download(CODE_KIND);
		for (i = 0; i < 8; i++)
			write_word(DL_ADDR_W'(2 * i), words[i]);
		end_download();
		idle(2);
		expected = '{flags: {words[1], words[0]}, addr: {words[3], words[2]},
			compare: {words[5], words[4]}, replace: {words[7], words[6]}};
		check_cheat("cheat", cheat, expected);
		if (valid_count - valid_start != 1)
			note_failure($sformatf("cheat_valid pulsed %0d times, expected once",
				valid_count - valid_start));
		if (reset_count - reset_start != 1)
			note_failure($sformatf("cheat_reset pulsed %0d times, expected once",
				reset_count - reset_start));
	endtask

	task automatic clear_with_pattern(input fill_pattern_e pattern);
		fill_write_t expected;
		int          count;
		count = 0;
		wait_clear_state(1'b0, WRAM_WORDS + 16);
		menu.fill_pattern = pattern;
		idle(2);
		start_download(8'h00);
		wait_clear_state(1'b1, 4);
		// Bounded walk over every fill write
		while (clear_busy && count < WRAM_WORDS + 16) begin
			expected = '{addr: WRAM_ADDR_W'(count),
				data: pattern_byte(pattern, WRAM_ADDR_W'(count)), wr: 1'b1};
			check_fill("fill", fill, expected);
			count++;
			@(negedge clk_sys);
		end
		end_download();
		if (count != WRAM_WORDS)
			note_failure($sformatf("Pattern %0d gave %0d fill writes, expected %0d",
				pattern, count, WRAM_WORDS));
		check_bit("clear_busy after clear", clear_busy, 1'b0);
	endtask

	task automatic ram_clear();
		clear_with_pattern(fill_9966);
		clear_with_pattern(fill_00ff);
		clear_with_pattern(fill_55);
		clear_with_pattern(fill_ff);
	endtask

	task automatic check_sectors(input string name, input logic is_load);
		sd_req_t expected;
		int      i;
		if (req_log.size() != 4)
			note_failure($sformatf("%s issued %0d sector requests, expected 4",
				name, req_log.size()));
		for (i = 0; i < req_log.size() && i < 4; i++) begin
			expected = '{lba: 32'(i), rd: is_load, wr: ~is_load};
			check_req(name, req_log[i], expected);
		end
	endtask

	task automatic auto_load();
		cart_info_t expected;
		menu.hdr_mode = mode_auto;
		img = '{mounted: 1'b1, readonly: 1'b0, size_nz: 1'b1};
		idle(2);
		req_log.delete();
		start_download(8'h00);
		// RAM size 1 gives a 2 KB backup RAM, four sectors
		write_word('0, 16'h0018);
		write_word(DL_ADDR_W'(2), 16'h0000);
		write_word(DL_ADDR_W'(4), 16'($random(seed)));
		end_download();
		// ROM size 8 is 256 KB
		expected = '{rom_type: 8'h00, rom_mask: 24'h03FFFF, ram_mask: 24'h0007FF,
			region: 1'b0};
		check_info("cart_info load", cart_info, expected);
		wait_backup_state(1'b1, 8);
		wait_backup_state(1'b0, 400);
		check_sectors("load request", 1'b1);
		check_bit("sd_req.rd after load", sd_req.rd, 1'b0);
	endtask

	task automatic autosave_flow();
		menu.autosave = 1'b1;
		osd_status    = 1'b0;
		idle(2);
		check_bit("led_user idle", led_user, 1'b0);
		bsram_write = 1'b1;
		@(negedge clk_sys);
		bsram_write = 1'b0;
		@(negedge clk_sys);
		check_bit("led_user pending", led_user, 1'b1);
		check_bit("bk_busy with OSD closed", bk_busy, 1'b0);
		req_log.delete();
		osd_status = 1'b1;
		wait_backup_state(1'b1, 8);
		wait_backup_state(1'b0, 400);
		osd_status = 1'b0;
		check_sectors("save request", 1'b0);
		check_bit("led_user after save", led_user, 1'b0);
	endtask

	// ====================
	// Main sequence
	// ====================
	initial begin
		int n;
		menu        = '0;
		dl          = '0;
		img         = '0;
		osd_status  = 1'b0;
		bsram_write = 1'b0;
		n = 0;
		while (RESET !== 1'b0 && n < 10) begin
			@(negedge clk_sys);
			n++;
		end
		if (RESET !== 1'b0)
			note_failure("Timeout: RESET was never released");
		idle(1);
		check_bit("clear_busy after reset", clear_busy, 1'b0);
		check_bit("bk_busy after reset", bk_busy, 1'b0);
		check_bit("cheat_valid after reset", cheat_valid, 1'b0);
		check_bit("sd_req.rd after reset", sd_req.rd, 1'b0);
		check_bit("sd_req.wr after reset", sd_req.wr, 1'b0);
		check_bit("led_user after reset", led_user, 1'b0);

		auto_header();
		forced_hirom();
		cheat_record();
		ram_clear();
		auto_load();
		autosave_flow();

		$display("Summary: %0d mismatches, %0d other failures", mismatch_count, failure_count);
		if (mismatch_count == 0 && failure_count == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

//--- cart_loader.f
verilog/cart_pkg.sv
verilog/loader_config.sv
verilog/header_detect.sv
verilog/cheat_assembler.sv
verilog/wram_clear.sv
verilog/backup_sequencer.sv
verilog/cart_loader.sv
bench/tb_clock.sv
bench/tb_cart_loader.sv

//--- run.sh
#!/bin/sh
# Builds the cart loader testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
	--top-module tb_cart_loader -f cart_loader.f -o sim_cart_loader

./obj_dir/sim_cart_loader > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: errors found" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"
